//--- run_sim.sh
#!/bin/sh
# Build and run the UART receive path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f uart_rx.f --top-module uart_rx_tb -o uart_rx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/uart_rx_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1

//--- rx_fifo.sv
// Character FIFO behind the receiver
// circular buffer with first-word fall-through read and sticky overflow

`timescale 1ns/1ps
`default_nettype none

module rx_fifo (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_rx_pkg::char_t  wr_data,
  input  logic                push,
  input  logic                pop,
  output uart_rx_pkg::char_t  rd_data,
  output logic                empty,
  output logic                overflow
);

  import uart_rx_pkg::*;

  char_t     mem [FIFO_DEPTH];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  logic      full;
  logic      do_push;
  logic      do_pop;

  // same address, wrap bits differ when full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                 (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;         // pop on empty is ignored

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      overflow <= 1'b0;
    end
    else if (push && full)
    begin
      overflow <= 1'b1;                   // held until reset
    end
  end

  assign rd_data = mem[rd_ptr[FIFO_AW-1:0]];  // oldest entry

  a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_ptr_t'(wr_ptr - rd_ptr) <= fifo_ptr_t'(FIFO_DEPTH))
    else $error("FIFO occupancy above depth");

  a_idle_ptrs: assert property (@(posedge clk) disable iff (!rst_n)
    (!push && !pop) |=> ($stable(wr_ptr) && $stable(rd_ptr)))
    else $error("FIFO pointers moved without push or pop");

endmodule

`default_nettype wire

//--- serial_rx.sv
// Serial receiver for 8N1 frames
// 3-flop synchronizer followed by an edge-tracking bit timer that
// resyncs on every data edge, rejects short glitches and flags line breaks

`timescale 1ns/1ps
`default_nettype none

module serial_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,          // async serial line, idle high
  output uart_rx_pkg::char_t  rx_char,
  output logic                rx_ready,    // one-cycle pulse per frame
  output logic                line_break
);

  import uart_rx_pkg::*;

  logic [2:0] sync;
  logic       rx_s;
  logic [9:0] shift_reg;
  logic [3:0] bit_cnt;
  bit_timer_t timer;
  rx_state_t  state;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync <= 3'b111;                      // line idles high
    end
    else
    begin
      sync <= {sync[1:0], rx};
    end
  end

  assign rx_s = sync[2];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      timer     <= '0;
      bit_cnt   <= '0;
      shift_reg <= '1;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (!rx_s)
          begin
            timer <= '0;
            state <= START;
          end
        end
        START:
        begin
          if (rx_s)                        // too short for a start bit
          begin
            state <= IDLE;
          end
          else if (timer < HALF_BIT_TIME)
          begin
            timer <= timer + 1'b1;
          end
          else
          begin
            bit_cnt <= '0;
            timer   <= '0;
            state   <= ZERO;
          end
        end
        ZERO:
        begin
          if (rx_s)                        // rising edge
          begin
            timer <= '0;
            state <= POS;
          end
          else if (timer < FULL_BIT_TIME)
          begin
            timer <= timer + 1'b1;
          end
          else
          begin
            shift_reg <= {1'b0, shift_reg[9:1]};
            bit_cnt   <= bit_cnt + 1'b1;
            timer     <= '0;
            state     <= (bit_cnt < 4'd8) ? ZERO : BREAK;
          end
        end
        POS:
        begin
          if (!rx_s)                       // glitch, back to the old bit
          begin
            timer <= timer + HALF_BIT_TIME;
            state <= ZERO;
          end
          else if (timer < HALF_BIT_TIME)
          begin
            timer <= timer + 1'b1;
          end
          else
          begin
            shift_reg <= {1'b1, shift_reg[9:1]};
            bit_cnt   <= bit_cnt + 1'b1;
            timer     <= '0;
            state     <= (bit_cnt < 4'd8) ? ONE : STOP;
          end
        end
        ONE:
        begin
          if (!rx_s)                       // falling edge
          begin
            timer <= '0;
            state <= NEG;
          end
          else if (timer < FULL_BIT_TIME)
          begin
            timer <= timer + 1'b1;
          end
          else
          begin
            shift_reg <= {1'b1, shift_reg[9:1]};
            bit_cnt   <= bit_cnt + 1'b1;
            timer     <= '0;
            state     <= (bit_cnt < 4'd8) ? ONE : STOP;
          end
        end
        NEG:
        begin
          if (rx_s)                        // glitch
          begin
            timer <= timer + HALF_BIT_TIME;
            state <= ONE;
          end
          else if (timer < HALF_BIT_TIME)
          begin
            timer <= timer + 1'b1;
          end
          else
          begin
            shift_reg <= {1'b0, shift_reg[9:1]};
            bit_cnt   <= bit_cnt + 1'b1;
            timer     <= '0;
            state     <= (bit_cnt < 4'd8) ? ZERO : BREAK;
          end
        end
        STOP:
        begin
          state <= IDLE;                   // single cycle
        end
        BREAK:
        begin
          if (!rx_s)
          begin
            timer <= '0;                   // line still low
          end
          else if (timer < HALF_BIT_TIME)
          begin
            timer <= timer + 1'b1;
          end
          else
          begin
            state <= IDLE;
          end
        end
        default:
        begin
          state <= HALT;                   // also holds HALT
        end
      endcase
    end
  end

  // the ninth shift is the stop bit, data sits below it
  assign rx_char    = shift_reg[8:1];
  assign rx_ready   = (state == STOP);
  assign line_break = (state == BREAK);

  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    rx_ready |=> !rx_ready)
    else $error("rx_ready high for more than one cycle");

  a_ready_break: assert property (@(posedge clk) disable iff (!rst_n)
    !(rx_ready && line_break))
    else $error("rx_ready and line_break both high");

endmodule

`default_nettype wire

//--- uart_rx.f
uart_rx_pkg.sv
serial_rx.sv
rx_fifo.sv
uart_rx_top.sv
uart_rx_tb.sv

//--- uart_rx_pkg.sv
// UART receive path shared definitions
// bit timing, FIFO sizing, vector types and the receiver state encoding

`default_nettype none

package uart_rx_pkg;

  // bit timing
  localparam int CLK_FREQ = 25_000_000;              // system clock in Hz
  localparam int BIT_FREQ = 1_562_500;               // baud rate
  localparam int BIT_TIME = CLK_FREQ / BIT_FREQ;     // clocks per bit
  localparam int TIMER_W  = $clog2(BIT_TIME);

  typedef logic [TIMER_W-1:0] bit_timer_t;

  localparam bit_timer_t FULL_BIT_TIME = bit_timer_t'(BIT_TIME - 1);
  localparam bit_timer_t HALF_BIT_TIME = bit_timer_t'((BIT_TIME >> 1) - 1);

  // character FIFO, depth must be a power of two
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  typedef logic [7:0]         char_t;      // one received character
  typedef logic [FIFO_AW:0]   fifo_ptr_t;  // address plus wrap bit

  // receiver states
  // ZERO/ONE time a steady bit, POS/NEG confirm an edge,
  // the low bit of the code follows the line level inside a frame
  typedef enum logic [3:0] {
    START = 4'h0,   // start edge seen, confirming
    STOP  = 4'h1,   // character ready, one cycle only
    ZERO  = 4'h4,   // line low
    POS   = 4'h5,   // rising edge, waiting half a bit
    NEG   = 4'h6,   // falling edge, waiting half a bit
    ONE   = 4'h7,   // line high
    HALT  = 4'hA,   // lock-up on a bad state code
    BREAK = 4'hE,   // low stop bit, waiting for idle line
    IDLE  = 4'hF    // waiting for a start edge
  } rx_state_t;

endpackage

`default_nettype wire

//--- uart_rx_tb.sv
// UART receive path testbench
// drives 8N1 frames onto rx, keeps a queue of expected characters and
// checks FIFO output, overflow and line break against it

`timescale 1ns/1ps
`default_nettype none

module uart_rx_tb;

  import uart_rx_pkg::*;

  localparam int FRAME_TIMEOUT = 20 * BIT_TIME;  // clocks, well over one frame
  localparam int BREAK_TIMEOUT = 4 * BIT_TIME;

  logic   clk;
  logic   rst_n;
  logic   rx;
  logic   pop;
  char_t  rd_data;
  logic   empty;
  logic   overflow;
  logic   line_break;

  integer seed;
  char_t  expected[$];                           // characters still to be popped
  logic   pre_frame;                             // nothing sent since reset
  logic   break_ok;
  logic   overflow_ok;

  uart_rx_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .pop        (pop),
    .rd_data    (rd_data),
    .empty      (empty),
    .overflow   (overflow),
    .line_break (line_break)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #20 clk = ~clk;
    end
  end

  task automatic report_error(input string msg);
    begin
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
    pre_frame |-> (empty && !overflow && !line_break))
    else report_error($sformatf("mismatch empty=%h overflow=%h line_break=%h after reset",
      empty, overflow, line_break));

  a_no_break: assert property (@(posedge clk) disable iff (!rst_n)
    !break_ok |-> !line_break)
    else report_error($sformatf("mismatch line_break=%h expected 0", line_break));

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    !overflow_ok |-> !overflow)
    else report_error($sformatf("mismatch overflow=%h expected 0", overflow));

  task automatic tick();
    begin
      @(posedge clk);
      #2;                                        // drive and sample point
    end
  endtask

  // characters with an edge at least every second bit, safe under skew
  function automatic char_t edge_rich_char(input int k);
    begin
      case (k % 4)
        0:       edge_rich_char = 8'h55;
        1:       edge_rich_char = 8'hAA;
        2:       edge_rich_char = 8'h33;
        default: edge_rich_char = 8'h66;
      endcase
    end
  endfunction

  // one frame, bits last BIT_TIME + skew clocks, optional 3-clock spike
  // starting 3 clocks into data bit glitch_bit, none when negative
  task automatic send_char(input char_t data, input logic stop_bit,
                           input int skew, input int glitch_bit);
    logic [9:0] frame;
    logic       bit_val;
    int         len;
    int         i;
    begin
      frame = {stop_bit, data, 1'b0};
      len   = BIT_TIME + skew;
      if (stop_bit)
      begin
        expected.push_back(data);
      end
      for (i = 0; i < 10; i++)
      begin
        bit_val = frame[0];
        frame   = frame >> 1;
        rx      = bit_val;
        if (glitch_bit >= 0 && i == glitch_bit + 1)
        begin
          repeat (3) tick();
          rx = ~bit_val;
          repeat (3) tick();
          rx = bit_val;
          repeat (len - 6) tick();
        end
        else
        begin
          repeat (len) tick();
        end
      end
      rx = 1'b1;                                 // back to idle
    end
  endtask

  task automatic wait_not_empty();
    int n;
    begin
      n = 0;
      while (empty && n < FRAME_TIMEOUT)
      begin
        tick();
        n++;
      end
      if (empty)
      begin
        report_error("timeout waiting for a received character");
      end
    end
  endtask

  task automatic pop_check();
    char_t exp;
    begin
      wait_not_empty();
      if (expected.size() == 0)
      begin
        report_error("received a character that was never sent");
      end
      exp = expected.pop_front();
      assert (rd_data == exp)
        else report_error($sformatf("mismatch rd_data=%h expected %h", rd_data, exp));
      pop = 1'b1;
      tick();
      pop = 1'b0;
    end
  endtask

  task automatic check_no_char(input int cycles);
    int n;
    begin
      for (n = 0; n < cycles; n++)
      begin
        tick();
        assert (empty)
          else report_error($sformatf("mismatch empty=%h expected 1", empty));
      end
    end
  endtask

  initial
  begin
    int    i;
    int    cnt;
    char_t c;
    seed        = 32'hc672_9cc5;
    rst_n       = 1'b0;
    rx          = 1'b1;
    pop         = 1'b0;
    pre_frame   = 1'b1;
    break_ok    = 1'b0;
    overflow_ok = 1'b0;
    repeat (4) tick();
    rst_n = 1'b1;
    repeat (2 * BIT_TIME) tick();                // quiet line after reset
    pre_frame = 1'b0;

    for (i = 0; i < 20; i++)
    begin
      c = char_t'($random(seed));
      send_char(c, 1'b1, 0, -1);
      pop_check();
    end

    for (i = 0; i < 8; i++)                      // stretched, then shortened bits
    begin
      send_char(edge_rich_char(i), 1'b1, (i < 4) ? 2 : -2, -1);
      pop_check();
    end

    rx = 1'b0;                                   // short low pulse on idle line
    repeat (3) tick();
    rx = 1'b1;
    check_no_char(2 * BIT_TIME);
    for (i = 0; i < 8; i++)                      // spike inside each data bit
    begin
      c = char_t'($random(seed));
      send_char(c, 1'b1, 0, i);
      pop_check();
    end

    break_ok = 1'b1;
    send_char(8'h00, 1'b0, 0, -1);
    assert (line_break)
      else report_error($sformatf("mismatch line_break=%h expected 1", line_break));
    cnt = 0;
    while (line_break && cnt < BREAK_TIMEOUT)
    begin
      tick();
      cnt++;
    end
    if (line_break)
    begin
      report_error("timeout waiting for line_break to fall");
    end
    // half a bit of high line plus the synchronizer
    assert (cnt >= BIT_TIME / 2 && cnt <= BIT_TIME / 2 + 4)
      else report_error($sformatf("line_break fell %0d clocks after the line went high", cnt));
    assert (empty)
      else report_error($sformatf("mismatch empty=%h expected 1", empty));
    break_ok = 1'b0;
    send_char(8'hA7, 1'b1, 0, -1);
    pop_check();

    overflow_ok = 1'b1;
    for (i = 0; i <= FIFO_DEPTH; i++)
    begin
      send_char(char_t'($random(seed)), 1'b1, 0, -1);
    end
    cnt = 0;
    while (!overflow && cnt < FRAME_TIMEOUT)
    begin
      tick();
      cnt++;
    end
    if (!overflow)
    begin
      report_error("timeout waiting for overflow");
    end
    c = expected.pop_back();                     // dropped by the full FIFO
    for (i = 0; i < FIFO_DEPTH; i++)
    begin
      pop_check();
    end
    assert (empty && overflow)
      else report_error($sformatf("mismatch empty=%h overflow=%h expected 1 1", empty, overflow));

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_rx_top.sv
// UART receive path top level
// serial receiver feeding the character FIFO

`timescale 1ns/1ps
`default_nettype none

module uart_rx_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  input  logic                pop,
  output uart_rx_pkg::char_t  rd_data,
  output logic                empty,
  output logic                overflow,
  output logic                line_break
);

  import uart_rx_pkg::*;

  char_t rx_char;
  logic  rx_ready;

  serial_rx u_serial_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .rx_char    (rx_char),
    .rx_ready   (rx_ready),
    .line_break (line_break)           // straight to the output
  );

  rx_fifo u_rx_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_data  (rx_char),
    .push     (rx_ready),
    .pop      (pop),
    .rd_data  (rd_data),
    .empty    (empty),
    .overflow (overflow)
  );

endmodule

`default_nettype wire
